// File: src/div_types_pkg.sv
`default_nettype none

package div_types_pkg;

   localparam int DATA_W = 32;                // operand width
   localparam int CYCLES = DATA_W;            // one quotient bit per iteration
   localparam int CNT_W  = $clog2(CYCLES);

   // counter value of the final iteration
   localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CYCLES - 1);

   // most negative two's complement value, used for the overflow case
   localparam logic [DATA_W-1:0] MOST_NEG = {1'b1, {(DATA_W-1){1'b0}}};

   // operation request as seen by the divider
   typedef struct packed {
      logic [DATA_W-1:0] dividend;
      logic [DATA_W-1:0] divisor;
      logic              is_signed;
   } div_req_t;

   // quotient and remainder
   typedef struct packed {
      logic [DATA_W-1:0] quotient;
      logic [DATA_W-1:0] remainder;
   } div_res_t;

   // unsigned magnitudes handed to the core
   typedef struct packed {
      logic [DATA_W-1:0] dividend;
      logic [DATA_W-1:0] divisor;
   } div_mag_t;

endpackage

`default_nettype wire

// File: src/div_apb_pkg.sv
`default_nettype none

package div_apb_pkg;

   localparam int ADDR_W     = 8;
   localparam int APB_DATA_W = 32;

   // register map, byte offsets
   localparam logic [ADDR_W-1:0] REG_DIVIDEND  = 8'h00;
   localparam logic [ADDR_W-1:0] REG_DIVISOR   = 8'h04;
   localparam logic [ADDR_W-1:0] REG_CTRL      = 8'h08;   // write starts the op
   localparam logic [ADDR_W-1:0] REG_STATUS    = 8'h0C;   // read only
   localparam logic [ADDR_W-1:0] REG_QUOTIENT  = 8'h10;   // read only
   localparam logic [ADDR_W-1:0] REG_REMAINDER = 8'h14;   // read only

   localparam int CTRL_SIGNED_BIT = 0;
   localparam int STATUS_BUSY_BIT = 0;
   localparam int STATUS_DONE_BIT = 1;   // sticky until next start

   typedef struct packed {
      logic                  psel;
      logic                  penable;
      logic                  pwrite;
      logic [ADDR_W-1:0]     paddr;
      logic [APB_DATA_W-1:0] pwdata;
   } apb_req_t;

   typedef struct packed {
      logic                  pready;
      logic [APB_DATA_W-1:0] prdata;
      logic                  pslverr;
   } apb_rsp_t;

endpackage

`default_nettype wire

// File: src/div_core.sv
`timescale 1ns/100ps
`default_nettype none

module div_core (
   input  logic                             i_clk,
   input  logic                             i_reset,
   input  logic                             i_start,
   input  logic [div_types_pkg::DATA_W-1:0] i_dividend,
   input  logic [div_types_pkg::DATA_W-1:0] i_divisor,
   output logic                             o_busy,
   output logic                             o_done,
   output div_types_pkg::div_res_t          o_res
);

   logic [div_types_pkg::DATA_W-1:0] rem_q;   // partial remainder
   logic [div_types_pkg::DATA_W-1:0] quo_q;   // dividend bits out, quotient bits in
   logic [div_types_pkg::DATA_W-1:0] dsr_q;
   logic [div_types_pkg::CNT_W-1:0]  cnt_q;

   logic [div_types_pkg::DATA_W:0]   rem_shift;
   logic [div_types_pkg::DATA_W:0]   diff;
   logic                             fits;
   logic [div_types_pkg::DATA_W-1:0] rem_next;
   logic [div_types_pkg::DATA_W-1:0] quo_next;
   logic                             load;
   logic                             last;

   assign load = i_start & ~o_busy;
   assign last = o_busy & (cnt_q == div_types_pkg::CNT_LAST);

   // one restoring step
   always_comb begin
      rem_shift = {rem_q, quo_q[div_types_pkg::DATA_W-1]};
      diff      = rem_shift - {1'b0, dsr_q};
      fits      = ~diff[div_types_pkg::DATA_W];   // no borrow
      rem_next  = fits ? diff[div_types_pkg::DATA_W-1:0]
                       : rem_shift[div_types_pkg::DATA_W-1:0];
      quo_next  = {quo_q[div_types_pkg::DATA_W-2:0], fits};
   end

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         o_busy <= 1'b0;
         o_done <= 1'b0;
         cnt_q  <= '0;
      end else begin
         o_done <= 1'b0;
         if (load) begin
            o_busy <= 1'b1;
            cnt_q  <= '0;
         end else if (o_busy) begin
            cnt_q <= cnt_q + 1'b1;
            if (last) begin
               o_busy <= 1'b0;
               o_done <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge i_clk) begin
      if (load) begin
         rem_q <= '0;
         quo_q <= i_dividend;
         dsr_q <= i_divisor;
      end else if (o_busy) begin
         rem_q <= rem_next;
         quo_q <= quo_next;
      end

      if (last) begin
         o_res.quotient  <= quo_next;
         o_res.remainder <= rem_next;
      end
   end

endmodule

`default_nettype wire

// File: src/big_divider.sv
`timescale 1ns/100ps
`default_nettype none

module big_divider (
   input  logic                    i_clk,
   input  logic                    i_reset,
   input  logic                    i_start,
   input  div_types_pkg::div_req_t i_req,
   output logic                    o_done,
   output div_types_pkg::div_res_t o_res
);

   logic                    dividend_neg;
   logic                    divisor_neg;
   logic                    div_by_zero;
   logic                    signed_ovf;
   logic                    special;
   logic                    accept;
   logic                    core_start;
   logic                    core_busy;
   logic                    core_done;
   logic                    quot_neg_q;
   logic                    rem_neg_q;
   div_types_pkg::div_mag_t mag;
   div_types_pkg::div_res_t core_res;
   div_types_pkg::div_res_t fixed;

   always_comb begin
      dividend_neg = i_req.is_signed & i_req.dividend[div_types_pkg::DATA_W-1];
      divisor_neg  = i_req.is_signed & i_req.divisor[div_types_pkg::DATA_W-1];

      div_by_zero = (i_req.divisor == '0);
      signed_ovf  = i_req.is_signed && (i_req.dividend == div_types_pkg::MOST_NEG) &&
                    (i_req.divisor == '1);
      special     = div_by_zero | signed_ovf;

      mag.dividend = dividend_neg ? -i_req.dividend : i_req.dividend;
      mag.divisor  = divisor_neg ? -i_req.divisor : i_req.divisor;
   end

   assign accept     = i_start & ~core_busy;
   assign core_start = accept & ~special;   // special cases bypass the core

   div_core u_core (
      .i_clk      (i_clk),
      .i_reset    (i_reset),
      .i_start    (core_start),
      .i_dividend (mag.dividend),
      .i_divisor  (mag.divisor),
      .o_busy     (core_busy),
      .o_done     (core_done),
      .o_res      (core_res)
   );

   // result signs for the fix-up
   always_ff @(posedge i_clk) begin
      if (core_start) begin
         quot_neg_q <= dividend_neg ^ divisor_neg;
         rem_neg_q  <= dividend_neg;   // remainder follows the dividend
      end
   end

   always_comb begin
      fixed.quotient  = quot_neg_q ? -core_res.quotient : core_res.quotient;
      fixed.remainder = rem_neg_q ? -core_res.remainder : core_res.remainder;
   end

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         o_done <= 1'b0;
      end else begin
         o_done <= (accept & special) | core_done;
      end
   end

   always_ff @(posedge i_clk) begin
      if (accept && div_by_zero) begin
         o_res.quotient  <= '1;
         o_res.remainder <= i_req.dividend;
      end else if (accept && signed_ovf) begin
         o_res.quotient  <= div_types_pkg::MOST_NEG;
         o_res.remainder <= '0;
      end else if (core_done) begin
         o_res <= fixed;
      end
   end

endmodule

`default_nettype wire

// File: src/div_apb_regs.sv
`timescale 1ns/100ps
`default_nettype none

module div_apb_regs (
   input  logic                    i_clk,
   input  logic                    i_reset,
   input  div_apb_pkg::apb_req_t   i_apb,
   output div_apb_pkg::apb_rsp_t   o_apb,
   output logic                    o_start,
   output div_types_pkg::div_req_t o_req,
   input  logic                    i_done,
   input  div_types_pkg::div_res_t i_res
);

   logic                               access;
   logic                               sel_dividend;
   logic                               sel_divisor;
   logic                               sel_ctrl;
   logic                               sel_status;
   logic                               sel_quotient;
   logic                               sel_remainder;
   logic                               mapped;
   logic                               read_only;
   logic                               err;
   logic                               wr_ok;
   logic                               busy_q;
   logic                               done_q;
   div_types_pkg::div_res_t            res_q;
   logic [div_apb_pkg::APB_DATA_W-1:0] rdata;

   assign access = i_apb.psel & i_apb.penable;

   // address decode
   always_comb begin
      sel_dividend  = (i_apb.paddr == div_apb_pkg::REG_DIVIDEND);
      sel_divisor   = (i_apb.paddr == div_apb_pkg::REG_DIVISOR);
      sel_ctrl      = (i_apb.paddr == div_apb_pkg::REG_CTRL);
      sel_status    = (i_apb.paddr == div_apb_pkg::REG_STATUS);
      sel_quotient  = (i_apb.paddr == div_apb_pkg::REG_QUOTIENT);
      sel_remainder = (i_apb.paddr == div_apb_pkg::REG_REMAINDER);

      mapped    = sel_dividend | sel_divisor | sel_ctrl |
                  sel_status | sel_quotient | sel_remainder;
      read_only = sel_status | sel_quotient | sel_remainder;

      // operands locked while an op is in flight
      err   = ~mapped | (i_apb.pwrite & (read_only | busy_q));
      wr_ok = access & i_apb.pwrite & ~err;
   end

   // read mux
   always_comb begin
      rdata = '0;
      if (sel_dividend) begin
         rdata = o_req.dividend;
      end else if (sel_divisor) begin
         rdata = o_req.divisor;
      end else if (sel_ctrl) begin
         rdata[div_apb_pkg::CTRL_SIGNED_BIT] = o_req.is_signed;
      end else if (sel_status) begin
         rdata[div_apb_pkg::STATUS_BUSY_BIT] = busy_q;
         rdata[div_apb_pkg::STATUS_DONE_BIT] = done_q;
      end else if (sel_quotient) begin
         rdata = res_q.quotient;
      end else if (sel_remainder) begin
         rdata = res_q.remainder;
      end
   end

   always_comb begin
      o_apb.pready  = access;   // no wait states
      o_apb.prdata  = access ? rdata : '0;
      o_apb.pslverr = access & err;
   end

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         o_req   <= '0;
         o_start <= 1'b0;
         busy_q  <= 1'b0;
         done_q  <= 1'b0;
         res_q   <= '0;
      end else begin
         o_start <= wr_ok & sel_ctrl;

         if (wr_ok && sel_dividend) begin
            o_req.dividend <= i_apb.pwdata;
         end
         if (wr_ok && sel_divisor) begin
            o_req.divisor <= i_apb.pwdata;
         end
         if (wr_ok && sel_ctrl) begin
            o_req.is_signed <= i_apb.pwdata[div_apb_pkg::CTRL_SIGNED_BIT];
            busy_q          <= 1'b1;
            done_q          <= 1'b0;
         end

         if (i_done) begin   // only arrives while busy
            res_q  <= i_res;
            busy_q <= 1'b0;
            done_q <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// File: src/div_apb_top.sv
`timescale 1ns/100ps
`default_nettype none

module div_apb_top (
   input  logic                  i_clk,
   input  logic                  i_reset,
   input  div_apb_pkg::apb_req_t i_apb,
   output div_apb_pkg::apb_rsp_t o_apb
);

   div_types_pkg::div_req_t div_req;
   div_types_pkg::div_res_t div_res;
   logic                    div_start;
   logic                    div_done;

   // register file and APB decode
   div_apb_regs u_regs (
      .i_clk   (i_clk),
      .i_reset (i_reset),
      .i_apb   (i_apb),
      .o_apb   (o_apb),
      .o_start (div_start),
      .o_req   (div_req),
      .i_done  (div_done),
      .i_res   (div_res)
   );

   // signed divider
   big_divider u_div (
      .i_clk   (i_clk),
      .i_reset (i_reset),
      .i_start (div_start),
      .i_req   (div_req),
      .o_done  (div_done),
      .o_res   (div_res)
   );

endmodule

`default_nettype wire

// File: test/div_apb_assert.sv
`timescale 1ns/100ps
`default_nettype none

module div_apb_assert (
   input logic                  i_clk,
   input logic                  i_reset,
   input div_apb_pkg::apb_req_t i_apb,
   input div_apb_pkg::apb_rsp_t i_apb_rsp,
   input logic                  i_start,
   input logic                  i_busy,
   input logic                  i_done
);

   int unsigned fail_count = 0;   // tally for the end of the run

   a_pready: assert property (@(posedge i_clk) disable iff (i_reset)
      (i_apb.psel && i_apb.penable) |-> i_apb_rsp.pready)
      else begin
         fail_count++;
         $error("pready low in an APB access phase");
      end

   // busy goes high together with the start pulse
   a_start_idle: assert property (@(posedge i_clk) disable iff (i_reset)
      $rose(i_start) |-> !$past(i_busy))
      else begin
         fail_count++;
         $error("start pulse while an operation was in flight");
      end

   a_done_pulse: assert property (@(posedge i_clk) disable iff (i_reset)
      i_done |=> !i_done)
      else begin
         fail_count++;
         $error("done held longer than one cycle");
      end

   a_reset_idle: assert property (@(posedge i_clk) i_reset |=> !i_busy)
      else begin
         fail_count++;
         $error("busy set right after reset");
      end

endmodule

bind div_apb_regs div_apb_assert u_assert (
   .i_clk     (i_clk),
   .i_reset   (i_reset),
   .i_apb     (i_apb),
   .i_apb_rsp (o_apb),
   .i_start   (o_start),
   .i_busy    (busy_q),
   .i_done    (i_done)
);

`default_nettype wire

// File: test/tb_div_apb_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_div_apb_top;

   localparam int PREADY_TIMEOUT = 20;    // cycles
   localparam int POLL_LIMIT     = 100;   // STATUS reads
   localparam int N_RANDOM       = 40;

   typedef struct packed {
      logic [div_types_pkg::DATA_W-1:0] dividend;
      logic [div_types_pkg::DATA_W-1:0] divisor;
      logic                             is_signed;
      div_types_pkg::div_res_t          exp;
   } case_t;

   logic                  clk;
   logic                  reset;
   div_apb_pkg::apb_req_t apb_req;
   div_apb_pkg::apb_rsp_t apb_rsp;
   case_t                 table_cases [14];

   div_apb_top UUT (
      .i_clk   (clk),
      .i_reset (reset),
      .i_apb   (apb_req),
      .o_apb   (apb_rsp)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   task automatic stop_run(input string msg);
      $display("ERRORS FOUND");
      $fatal(1, "%s", msg);
   endtask

   task automatic check_res(input div_types_pkg::div_res_t got,
                            input div_types_pkg::div_res_t exp, input string what);
      if (got !== exp) begin
         $display("ERROR at %0d ns: %s gave q=%h r=%h, expected q=%h r=%h", $time, what,
                  got.quotient, got.remainder, exp.quotient, exp.remainder);
         stop_run("division result mismatch");
      end
   endtask

   task automatic check_rsp(input div_apb_pkg::apb_rsp_t got, input logic exp_err,
                            input string what);
      if (got.pslverr !== exp_err) begin
         $display("ERROR at %0d ns: %s gave pslverr %b, expected %b", $time, what,
                  got.pslverr, exp_err);
         stop_run("APB error response mismatch");
      end
   endtask

   task automatic check_word(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
      if (got !== exp) begin
         $display("ERROR at %0d ns: %s read %h, expected %h", $time, what, got, exp);
         stop_run("register read mismatch");
      end
   endtask

   // setup cycle, access cycle, then idle
   task automatic apb_access(input logic write, input logic [div_apb_pkg::ADDR_W-1:0] addr,
                             input logic [31:0] wdata, output div_apb_pkg::apb_rsp_t rsp);
      int waited;
      waited = 0;
      @(posedge clk);
      apb_req.psel    <= 1'b1;
      apb_req.penable <= 1'b0;
      apb_req.pwrite  <= write;
      apb_req.paddr   <= addr;
      apb_req.pwdata  <= wdata;
      @(posedge clk);
      apb_req.penable <= 1'b1;
      @(negedge clk);
      while (!apb_rsp.pready) begin
         if (waited == PREADY_TIMEOUT) begin
            stop_run("timeout waiting for pready");
         end
         waited++;
         @(negedge clk);
      end
      rsp = apb_rsp;
      @(posedge clk);
      apb_req.psel    <= 1'b0;
      apb_req.penable <= 1'b0;
   endtask

   task automatic apb_write(input logic [div_apb_pkg::ADDR_W-1:0] addr,
                            input logic [31:0] data, output div_apb_pkg::apb_rsp_t rsp);
      apb_access(1'b1, addr, data, rsp);
   endtask

   task automatic apb_read(input logic [div_apb_pkg::ADDR_W-1:0] addr,
                           output div_apb_pkg::apb_rsp_t rsp);
      apb_access(1'b0, addr, '0, rsp);
   endtask

   task automatic start_div(input logic [31:0] dividend, input logic [31:0] divisor,
                            input logic is_signed);
      div_apb_pkg::apb_rsp_t rsp;
      apb_write(div_apb_pkg::REG_DIVIDEND, dividend, rsp);
      check_rsp(rsp, 1'b0, "DIVIDEND write");
      apb_write(div_apb_pkg::REG_DIVISOR, divisor, rsp);
      check_rsp(rsp, 1'b0, "DIVISOR write");
      apb_write(div_apb_pkg::REG_CTRL, {31'b0, is_signed}, rsp);
      check_rsp(rsp, 1'b0, "CTRL write");
   endtask

   task automatic finish_div(output div_types_pkg::div_res_t res);
      div_apb_pkg::apb_rsp_t rsp;
      int                    polls;
      polls = 0;
      apb_read(div_apb_pkg::REG_STATUS, rsp);
      while (!rsp.prdata[div_apb_pkg::STATUS_DONE_BIT]) begin
         if (polls == POLL_LIMIT) begin
            stop_run("timeout waiting for the done bit in STATUS");
         end
         polls++;
         apb_read(div_apb_pkg::REG_STATUS, rsp);
      end
      check_word(rsp.prdata, 32'h2, "STATUS at end of operation");   // done, not busy
      apb_read(div_apb_pkg::REG_QUOTIENT, rsp);
      check_rsp(rsp, 1'b0, "QUOTIENT read");
      res.quotient = rsp.prdata;
      apb_read(div_apb_pkg::REG_REMAINDER, rsp);
      check_rsp(rsp, 1'b0, "REMAINDER read");
      res.remainder = rsp.prdata;
   endtask

   // RV32M division as written in the ISA
   function automatic div_types_pkg::div_res_t ref_divide(input logic [31:0] a,
                                                          input logic [31:0] b,
                                                          input logic sgn);
      div_types_pkg::div_res_t r;
      if (b == 32'h0) begin
         r.quotient  = '1;
         r.remainder = a;
      end else if (sgn && a == 32'h8000_0000 && b == 32'hFFFF_FFFF) begin
         r.quotient  = 32'h8000_0000;
         r.remainder = '0;
      end else if (sgn) begin
         r.quotient  = $signed(a) / $signed(b);   // truncates toward zero
         r.remainder = $signed(a) % $signed(b);
      end else begin
         r.quotient  = a / b;
         r.remainder = a % b;
      end
      return r;
   endfunction

   function automatic case_t table_entry(input logic [31:0] a, input logic [31:0] b,
                                         input logic sgn, input logic [31:0] q,
                                         input logic [31:0] r);
      case_t c;
      c.dividend      = a;
      c.divisor       = b;
      c.is_signed     = sgn;
      c.exp.quotient  = q;
      c.exp.remainder = r;
      return c;
   endfunction

   initial begin
      div_types_pkg::div_res_t res;
      div_types_pkg::div_res_t exp_res;
      div_apb_pkg::apb_rsp_t   rsp;
      logic [31:0]             a;
      logic [31:0]             b;
      logic [31:0]             rnd;

      void'($urandom(67993));
      apb_req = '0;
      reset   = 1'b1;

      table_cases[0]  = table_entry(32'd100, 32'd7, 1'b0, 32'd14, 32'd2);
      table_cases[1]  = table_entry(32'd5, 32'd9, 1'b0, 32'd0, 32'd5);
      table_cases[2]  = table_entry(32'hDEADBEEF, 32'd1, 1'b0, 32'hDEADBEEF, 32'd0);
      table_cases[3]  = table_entry(32'hFFFFFFFF, 32'h10, 1'b0, 32'h0FFFFFFF, 32'hF);
      table_cases[4]  = table_entry(32'h80000000, 32'hFFFFFFFF, 1'b0, 32'd0, 32'h80000000);
      table_cases[5]  = table_entry(32'd100, 32'd7, 1'b1, 32'd14, 32'd2);
      table_cases[6]  = table_entry(32'hFFFFFF9C, 32'd7, 1'b1, 32'hFFFFFFF2, 32'hFFFFFFFE);
      table_cases[7]  = table_entry(32'd100, 32'hFFFFFFF9, 1'b1, 32'hFFFFFFF2, 32'd2);
      table_cases[8]  = table_entry(32'hFFFFFF9C, 32'hFFFFFFF9, 1'b1, 32'hE, 32'hFFFFFFFE);
      table_cases[9]  = table_entry(32'hFFFFFFF9, 32'd100, 1'b1, 32'd0, 32'hFFFFFFF9);
      table_cases[10] = table_entry(32'h80000000, 32'd2, 1'b1, 32'hC0000000, 32'd0);
      table_cases[11] = table_entry(32'h80000000, 32'hFFFFFFFF, 1'b1, 32'h80000000, 32'd0);
      table_cases[12] = table_entry(32'h12345678, 32'd0, 1'b0, 32'hFFFFFFFF, 32'h12345678);
      table_cases[13] = table_entry(32'hFFFFFF9C, 32'd0, 1'b1, 32'hFFFFFFFF, 32'hFFFFFF9C);

      repeat (4) @(posedge clk);
      reset <= 1'b0;

      apb_read(div_apb_pkg::REG_STATUS, rsp);
      check_word(rsp.prdata, 32'h0, "STATUS after reset");
      apb_read(div_apb_pkg::REG_QUOTIENT, rsp);
      check_word(rsp.prdata, 32'h0, "QUOTIENT after reset");

      foreach (table_cases[i]) begin
         start_div(table_cases[i].dividend, table_cases[i].divisor, table_cases[i].is_signed);
         finish_div(res);
         check_res(res, table_cases[i].exp, $sformatf("table entry %0d", i));
      end

      for (int n = 0; n < N_RANDOM; n++) begin
         a   = $urandom;
         b   = $urandom;
         rnd = $urandom;
         if (rnd[3:1] == 3'd0) begin
            b = {28'b0, rnd[7:4]};   // small divisor, zero now and then
         end
         start_div(a, b, rnd[0]);
         finish_div(res);
         check_res(res, ref_divide(a, b, rnd[0]), $sformatf("random case %0d", n));
      end

      // bus errors while an operation is in flight
      start_div(32'd1000000, 32'd3, 1'b0);
      apb_write(div_apb_pkg::REG_DIVISOR, 32'd5, rsp);
      check_rsp(rsp, 1'b1, "DIVISOR write while busy");
      apb_write(div_apb_pkg::REG_CTRL, 32'h1, rsp);
      check_rsp(rsp, 1'b1, "CTRL write while busy");
      apb_write(div_apb_pkg::REG_QUOTIENT, 32'hFFFF_FFFF, rsp);
      check_rsp(rsp, 1'b1, "QUOTIENT write");
      apb_read(8'h20, rsp);
      check_rsp(rsp, 1'b1, "read of unmapped address");
      apb_read(div_apb_pkg::REG_DIVISOR, rsp);
      check_rsp(rsp, 1'b0, "DIVISOR read while busy");
      check_word(rsp.prdata, 32'd3, "DIVISOR after refused write");
      apb_read(div_apb_pkg::REG_CTRL, rsp);
      check_word(rsp.prdata, 32'h0, "CTRL after refused write");
      finish_div(res);
      exp_res.quotient  = 32'd333333;
      exp_res.remainder = 32'd1;
      check_res(res, exp_res, "operation with refused writes");

      if (UUT.u_regs.u_assert.fail_count == 0) begin
         $display("NO ERRORS");
         $finish;
      end else begin
         $display("ERRORS FOUND");
         $fatal(1, "the bound checker reported assertion failures");
      end
   end

endmodule

`default_nettype wire

// File: files.f
src/div_types_pkg.sv
src/div_apb_pkg.sv
src/div_core.sv
src/big_divider.sv
src/div_apb_regs.sv
src/div_apb_top.sv
test/div_apb_assert.sv
test/tb_div_apb_top.sv

// File: Makefile
# Verilator build and run of the APB divider testbench

VERILATOR ?= verilator
TOP       ?= tb_div_apb_top
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
